// File: lb_params.svh
/* Sizes and fixed numbers for the load-balancing control plane.
   Include wherever core counts, slot widths or FIFO depths are needed. */
`ifndef LB_PARAMS_SVH
`define LB_PARAMS_SVH

// Core population
`define LB_CORE_COUNT 4
`define LB_CORE_ID_WIDTH 2

// Slots per core, count width holds 0 to LB_SLOT_COUNT
`define LB_SLOT_COUNT 8
`define LB_SLOT_WIDTH 4

// Control message layout
`define LB_MSG_TYPE_WIDTH 4
`define LB_PAYLOAD_WIDTH 32

// Packet-done queue depth as log2
`define LB_DONE_FIFO_DEPTH_LOG2 3

// Port that loopback descriptors are steered to
`define LB_LOOPBACK_PORT 3

`endif

// File: lb_pkg.sv
/* Message, payload and register bus types shared by the controller,
   the register block and the top level. */
`default_nettype none

`include "lb_params.svh"

package lb_pkg;

  // Inbound message types
  typedef enum logic [`LB_MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_FREE   = 4'd0,
    MSG_PKT_DONE    = 4'd1,
    MSG_PKT_TO_CORE = 4'd2,
    MSG_SLOT_INIT   = 4'd3
  } lb_msg_type_e;

  // Outbound types reuse the low encodings
  localparam lb_msg_type_e OUT_SEND_OUT = MSG_SLOT_FREE;
  localparam lb_msg_type_e OUT_LOOPBACK = MSG_PKT_DONE;

  // Slot free and slot init view
  typedef struct packed {
    logic [7:0]  rsvd_hi;
    logic [7:0]  slot;
    logic [15:0] rsvd_lo;
  } lb_slot_msg_t;

  // Packet done and packet to core view
  typedef struct packed {
    logic [7:0]  dest_core;
    logic [7:0]  src_slot;
    logic [15:0] info;
  } lb_pkt_msg_t;

  typedef union packed {
    lb_slot_msg_t slot;
    lb_pkt_msg_t  pkt;
  } lb_payload_u;

  typedef struct packed {
    lb_msg_type_e msg_type;
    lb_payload_u  payload;
  } lb_ctrl_msg_t;

  // Single-cycle register strobes from the host
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } lb_cfg_req_t;

endpackage

`default_nettype wire

// File: lb_fifo.sv
/* Register-array FIFO with a valid/ready handshake on both sides.
   Holds the packet-done messages and each core's to-core requests. */
`timescale 1ns/100ps
`default_nettype none

module lb_fifo #(
  parameter int DEPTH_LOG2 = 3,
  parameter int WIDTH      = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [WIDTH-1:0]    mem [DEPTH];
  // Extra pointer bit tells full from empty
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;
  logic                full;
  logic                push;
  logic                pop;

  assign full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  assign in_ready  = !full;
  assign out_valid = (wr_ptr != rd_ptr);
  assign out_data  = mem[rd_ptr[DEPTH_LOG2-1:0]];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy never passes the depth, so no push lands on a full FIFO
  a_no_overfill: assert property (@(posedge clk) disable iff (rst)
    (DEPTH_LOG2 + 1)'(wr_ptr - rd_ptr) <= DEPTH);

endmodule

`default_nettype wire

// File: slot_keeper.sv
/* Free-slot pool of one core, kept as a circular FIFO of slot numbers.
   Init loads slots 1..N, enqueue returns a slot, pop hands out the head. */
`timescale 1ns/100ps
`default_nettype none

`include "lb_params.svh"

module slot_keeper (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush,
  input  logic                      init_valid,
  input  logic [`LB_SLOT_WIDTH-1:0] init_count,
  input  logic [`LB_SLOT_WIDTH-1:0] slot_in,
  input  logic                      slot_in_valid,
  output logic [`LB_SLOT_WIDTH-1:0] slot_out,
  output logic                      slot_out_valid,
  input  logic                      slot_out_pop,
  output logic [`LB_SLOT_WIDTH-1:0] slot_count,
  output logic                      enq_err
);

  localparam int PTR_W = $clog2(`LB_SLOT_COUNT);

  logic [`LB_SLOT_WIDTH-1:0] mem [`LB_SLOT_COUNT];
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W-1:0]          wr_ptr;
  logic [`LB_SLOT_WIDTH-1:0] init_n;
  logic                      pop;
  logic                      enq;

  // Init clamps to the pool size
  assign init_n = (init_count > `LB_SLOT_COUNT) ? `LB_SLOT_WIDTH'(`LB_SLOT_COUNT) : init_count;

  assign slot_out_valid = (slot_count != '0);
  assign slot_out       = mem[rd_ptr];
  assign pop            = slot_out_pop && slot_out_valid;
  // A full pool still takes a slot when the head leaves in the same cycle
  assign enq            = slot_in_valid && ((slot_count < `LB_SLOT_COUNT) || pop);

  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `LB_SLOT_COUNT; i++) begin
        mem[i] <= `LB_SLOT_WIDTH'(i + 1);
      end
    end else if (enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
      enq_err    <= 1'b0;
    end else if (init_valid) begin
      rd_ptr     <= '0;
      wr_ptr     <= PTR_W'(init_n);
      slot_count <= init_n;
      enq_err    <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      slot_count <= slot_count + `LB_SLOT_WIDTH'(enq) - `LB_SLOT_WIDTH'(pop);
      // Dropped slot
      enq_err    <= slot_in_valid && !enq;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    slot_count <= `LB_SLOT_COUNT);

endmodule

`default_nettype wire

// File: lb_controller.sv
/* Control message engine: classifies inbound messages, keeps per-core slot pools,
   grants to-core requests round robin and registers the outbound stream. */
`timescale 1ns/100ps
`default_nettype none

`include "lb_params.svh"

module lb_controller (
  input  logic                                             clk,
  input  logic                                             rst,
  input  lb_pkg::lb_ctrl_msg_t                             ctrl_in,
  input  logic                                             ctrl_in_valid,
  output logic                                             ctrl_in_ready,
  input  logic [`LB_CORE_ID_WIDTH-1:0]                     ctrl_in_src,
  output lb_pkg::lb_ctrl_msg_t                             ctrl_out,
  output logic                                             ctrl_out_valid,
  input  logic                                             ctrl_out_ready,
  output logic [`LB_CORE_ID_WIDTH-1:0]                     ctrl_out_dest,
  input  logic [`LB_CORE_COUNT-1:0]                        enabled_cores,
  input  logic [`LB_CORE_COUNT-1:0]                        slots_flush,
  output logic [`LB_CORE_COUNT-1:0][`LB_SLOT_WIDTH-1:0]    slot_counts,
  output logic                                             slot_err
);

  import lb_pkg::*;

  localparam int QUEUE_DEPTH_LOG2 = $clog2(`LB_SLOT_COUNT);
  localparam int REQ_WIDTH        = `LB_CORE_ID_WIDTH + `LB_PAYLOAD_WIDTH;

  // Queued request, sender plus packet view of the payload
  typedef struct packed {
    logic [`LB_CORE_ID_WIDTH-1:0] src;
    lb_pkt_msg_t                  pkt;
  } req_t;

  lb_msg_type_e                                  in_type;
  lb_pkt_msg_t                                   in_pkt;
  lb_slot_msg_t                                  in_slot;
  logic [`LB_CORE_ID_WIDTH-1:0]                  in_dest;
  req_t                                          in_req;

  req_t                                          done_out;
  logic                                          done_in_ready;
  logic                                          done_valid;
  logic                                          done_ready;

  req_t [`LB_CORE_COUNT-1:0]                     q_out;
  logic [`LB_CORE_COUNT-1:0]                     q_in_ready;
  logic [`LB_CORE_COUNT-1:0]                     q_valid;
  logic [`LB_CORE_COUNT-1:0]                     grant_pop;

  logic [`LB_CORE_COUNT-1:0]                     enq_v;
  logic [`LB_CORE_COUNT-1:0]                     init_v;
  logic [`LB_SLOT_WIDTH-1:0]                     upd_slot;
  logic [`LB_CORE_COUNT-1:0][`LB_SLOT_WIDTH-1:0] next_slot;
  logic [`LB_CORE_COUNT-1:0]                     slot_valid;
  logic [`LB_CORE_COUNT-1:0]                     keeper_err;

  logic [`LB_CORE_COUNT-1:0]                     eligible;
  logic [`LB_CORE_ID_WIDTH-1:0]                  rr_last;
  logic [`LB_CORE_ID_WIDTH-1:0]                  grant_idx;
  logic                                          grant_any;
  req_t                                          sel_req;
  lb_pkt_msg_t                                   lb_pkt;

  logic                                          last_lb;
  logic                                          sel_lb;
  logic                                          load;
  logic                                          lb_take;

  // Decode the payload by message type
  assign in_type = ctrl_in.msg_type;
  assign in_pkt  = ctrl_in.payload.pkt;
  assign in_slot = ctrl_in.payload.slot;
  assign in_dest = in_pkt.dest_core[`LB_CORE_ID_WIDTH-1:0];
  assign in_req  = '{src: ctrl_in_src, pkt: in_pkt};

  always_comb begin
    case (in_type)
      MSG_PKT_DONE:    ctrl_in_ready = done_in_ready;
      MSG_PKT_TO_CORE: ctrl_in_ready = q_in_ready[in_dest];
      default:         ctrl_in_ready = 1'b1;
    endcase
  end

  lb_fifo #(
    .DEPTH_LOG2 (`LB_DONE_FIFO_DEPTH_LOG2),
    .WIDTH      (REQ_WIDTH)
  ) done_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_req),
    .in_valid  (ctrl_in_valid && (in_type == MSG_PKT_DONE)),
    .in_ready  (done_in_ready),
    .out_data  (done_out),
    .out_valid (done_valid),
    .out_ready (done_ready)
  );

  // Slot updates pass one register stage before the keepers
  always_ff @(posedge clk) begin
    if (|in_slot.slot[7:`LB_SLOT_WIDTH]) begin
      upd_slot <= '1;
    end else begin
      upd_slot <= in_slot.slot[`LB_SLOT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enq_v  <= '0;
      init_v <= '0;
    end else begin
      enq_v  <= '0;
      init_v <= '0;
      if (ctrl_in_valid) begin
        enq_v[ctrl_in_src]  <= (in_type == MSG_SLOT_FREE);
        init_v[ctrl_in_src] <= (in_type == MSG_SLOT_INIT);
      end
    end
  end

  for (genvar c = 0; c < `LB_CORE_COUNT; c++) begin : g_core
    lb_fifo #(
      .DEPTH_LOG2 (QUEUE_DEPTH_LOG2),
      .WIDTH      (REQ_WIDTH)
    ) to_core_fifo_i (
      .clk       (clk),
      .rst       (rst),
      .in_data   (in_req),
      .in_valid  (ctrl_in_valid && (in_type == MSG_PKT_TO_CORE) &&
                  (in_dest == `LB_CORE_ID_WIDTH'(c))),
      .in_ready  (q_in_ready[c]),
      .out_data  (q_out[c]),
      .out_valid (q_valid[c]),
      .out_ready (grant_pop[c])
    );

    slot_keeper slot_keeper_i (
      .clk            (clk),
      .rst            (rst),
      .flush          (slots_flush[c]),
      .init_valid     (init_v[c]),
      .init_count     (upd_slot),
      .slot_in        (upd_slot),
      .slot_in_valid  (enq_v[c]),
      .slot_out       (next_slot[c]),
      .slot_out_valid (slot_valid[c]),
      .slot_out_pop   (grant_pop[c]),
      .slot_count     (slot_counts[c]),
      .enq_err        (keeper_err[c])
    );

    assign grant_pop[c] = lb_take && (grant_idx == `LB_CORE_ID_WIDTH'(c));
  end

  assign slot_err = |keeper_err;

  // Round robin over queues whose core is enabled and has a slot
  assign eligible = q_valid & slot_valid & enabled_cores;

  always_comb begin
    logic [`LB_CORE_ID_WIDTH-1:0] idx;
    idx       = rr_last;
    grant_idx = rr_last;
    grant_any = 1'b0;
    for (int k = 1; k <= `LB_CORE_COUNT; k++) begin
      idx = `LB_CORE_ID_WIDTH'(rr_last + k);
      if (!grant_any && eligible[idx]) begin
        grant_idx = idx;
        grant_any = 1'b1;
      end
    end
  end

  // Loopback descriptor rewrite
  assign sel_req          = q_out[grant_idx];
  assign lb_pkt.dest_core = 8'(`LB_LOOPBACK_PORT);
  assign lb_pkt.src_slot  = sel_req.pkt.src_slot;
  assign lb_pkt.info      = {4'(grant_idx), 12'(next_slot[grant_idx])};

  // Alternate between done and loopback when both wait
  assign load       = !ctrl_out_valid || ctrl_out_ready;
  assign sel_lb     = grant_any && (!done_valid || !last_lb);
  assign lb_take    = load && sel_lb;
  assign done_ready = load && !sel_lb;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_out_valid <= 1'b0;
      last_lb        <= 1'b0;
      rr_last        <= '0;
    end else begin
      if (load) begin
        ctrl_out_valid <= grant_any || done_valid;
      end
      if (load && (grant_any || done_valid)) begin
        last_lb <= sel_lb;
      end
      if (lb_take) begin
        rr_last <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ctrl_out.msg_type    <= sel_lb ? OUT_LOOPBACK : OUT_SEND_OUT;
      ctrl_out.payload.pkt <= sel_lb ? lb_pkt : done_out.pkt;
      ctrl_out_dest        <= sel_lb ? sel_req.src : done_out.src;
    end
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    ctrl_out_valid && !ctrl_out_ready |=>
      ctrl_out_valid && $stable(ctrl_out) && $stable(ctrl_out_dest));

endmodule

`default_nettype wire

// File: lb_config_regs.sv
/* Host register block: enable mask, flush strobes, sticky slot error
   and slot count readback, with read data one cycle after the strobe. */
`timescale 1ns/100ps
`default_nettype none

`include "lb_params.svh"

module lb_config_regs (
  input  logic                                          clk,
  input  logic                                          rst,
  input  lb_pkg::lb_cfg_req_t                           cfg_req,
  output logic [31:0]                                   cfg_rdata,
  output logic                                          cfg_rvalid,
  output logic [`LB_CORE_COUNT-1:0]                     enabled_cores,
  output logic [`LB_CORE_COUNT-1:0]                     slots_flush,
  input  logic [`LB_CORE_COUNT-1:0][`LB_SLOT_WIDTH-1:0] slot_counts,
  input  logic                                          slot_err
);

  logic        err_sticky;
  logic [31:0] rdata_next;

  // Flush follows the write strobe directly
  assign slots_flush = (cfg_req.wr && (cfg_req.addr == 4'd1)) ?
                       cfg_req.wdata[`LB_CORE_COUNT-1:0] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      enabled_cores <= '0;
      err_sticky    <= 1'b0;
      cfg_rvalid    <= 1'b0;
    end else begin
      if (cfg_req.wr && (cfg_req.addr == 4'd0)) begin
        enabled_cores <= cfg_req.wdata[`LB_CORE_COUNT-1:0];
      end
      // Write clears, a new error in the same cycle still sticks
      if (cfg_req.wr && (cfg_req.addr == 4'd2)) begin
        err_sticky <= slot_err;
      end else begin
        err_sticky <= err_sticky || slot_err;
      end
      cfg_rvalid <= cfg_req.rd;
    end
  end

  always_comb begin
    case (cfg_req.addr)
      4'd0:                   rdata_next = 32'(enabled_cores);
      4'd2:                   rdata_next = 32'(err_sticky);
      4'd4, 4'd5, 4'd6, 4'd7: rdata_next =
                                32'(slot_counts[cfg_req.addr[`LB_CORE_ID_WIDTH-1:0]]);
      default:                rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cfg_req.rd) begin
      cfg_rdata <= rdata_next;
    end
  end

endmodule

`default_nettype wire

// File: lb_top.sv
/* Top level of the control plane, joining the host register block
   to the message controller. */
`timescale 1ns/100ps
`default_nettype none

`include "lb_params.svh"

module lb_top (
  input  logic                         clk,
  input  logic                         rst,
  input  lb_pkg::lb_ctrl_msg_t         ctrl_in,
  input  logic                         ctrl_in_valid,
  output logic                         ctrl_in_ready,
  input  logic [`LB_CORE_ID_WIDTH-1:0] ctrl_in_src,
  output lb_pkg::lb_ctrl_msg_t         ctrl_out,
  output logic                         ctrl_out_valid,
  input  logic                         ctrl_out_ready,
  output logic [`LB_CORE_ID_WIDTH-1:0] ctrl_out_dest,
  input  lb_pkg::lb_cfg_req_t          cfg_req,
  output logic [31:0]                  cfg_rdata,
  output logic                         cfg_rvalid
);

  logic [`LB_CORE_COUNT-1:0]                     enabled_cores;
  logic [`LB_CORE_COUNT-1:0]                     slots_flush;
  logic [`LB_CORE_COUNT-1:0][`LB_SLOT_WIDTH-1:0] slot_counts;
  logic                                          slot_err;

  lb_config_regs lb_config_regs_i (
    .clk           (clk),
    .rst           (rst),
    .cfg_req       (cfg_req),
    .cfg_rdata     (cfg_rdata),
    .cfg_rvalid    (cfg_rvalid),
    .enabled_cores (enabled_cores),
    .slots_flush   (slots_flush),
    .slot_counts   (slot_counts),
    .slot_err      (slot_err)
  );

  lb_controller lb_controller_i (
    .clk            (clk),
    .rst            (rst),
    .ctrl_in        (ctrl_in),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_out       (ctrl_out),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .ctrl_out_dest  (ctrl_out_dest),
    .enabled_cores  (enabled_cores),
    .slots_flush    (slots_flush),
    .slot_counts    (slot_counts),
    .slot_err       (slot_err)
  );

endmodule

`default_nettype wire

// File: tb_lb_top.sv
/* Table-driven testbench for lb_top with a queue model of slot pools and outbound beats.
   Run as the simulation top; it prints a line per test, a count summary and a result line. */
`timescale 1ns/100ps
`default_nettype none

`include "lb_params.svh"

module tb_lb_top;

  import lb_pkg::*;

  localparam logic [2:0] K_WR  = 3'd0;
  localparam logic [2:0] K_RD  = 3'd1;
  localparam logic [2:0] K_MSG = 3'd2;
  localparam logic [2:0] K_RDY = 3'd3;

  // One table row
  typedef struct packed {
    logic [2:0]  kind;
    logic [2:0]  test;
    logic [1:0]  src;
    logic [3:0]  msg_type;
    logic [31:0] payload;
    logic [3:0]  addr;
    logic [31:0] data;
  } step_t;

  logic                         clk;
  logic                         rst;
  lb_ctrl_msg_t                 ctrl_in;
  logic                         ctrl_in_valid;
  logic                         ctrl_in_ready;
  logic [`LB_CORE_ID_WIDTH-1:0] ctrl_in_src;
  lb_ctrl_msg_t                 ctrl_out;
  logic                         ctrl_out_valid;
  logic                         ctrl_out_ready;
  logic [`LB_CORE_ID_WIDTH-1:0] ctrl_out_dest;
  lb_cfg_req_t                  cfg_req;
  logic [31:0]                  cfg_rdata;
  logic                         cfg_rvalid;

  step_t steps [64];
  int    n_steps;
  bit    built;
  int    seed;
  int    rdy_mode;
  int    checks;
  int    fails;
  int    test_errs;
  int    cur_test;

  // Model of slot pools, enable mask, waiting requests and expected beats
  logic [3:0]  pool [`LB_CORE_COUNT][`LB_SLOT_COUNT];
  int          pool_head [`LB_CORE_COUNT];
  int          pool_cnt [`LB_CORE_COUNT];
  logic [3:0]  enable_m;
  logic [33:0] pend_q [$];
  // Stream tag in 40:36 and message in 35:0
  logic [40:0] exp_q [$];

  lb_top lb_top_i (
    .clk            (clk),
    .rst            (rst),
    .ctrl_in        (ctrl_in),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_out       (ctrl_out),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .ctrl_out_dest  (ctrl_out_dest),
    .cfg_req        (cfg_req),
    .cfg_rdata      (cfg_rdata),
    .cfg_rvalid     (cfg_rvalid)
  );

  always #4 clk = ~clk;

  // Output ready level per mode, random in stall mode
  always @(posedge clk) begin
    if (rdy_mode == 2) begin
      ctrl_out_ready <= (($random(seed) & 1) != 0);
    end else begin
      ctrl_out_ready <= (rdy_mode != 0);
    end
  end

  // Every accepted outbound beat is checked against the model
  always @(negedge clk) begin
    if (!rst && ctrl_out_valid && ctrl_out_ready) begin
      check_beat();
    end
  end

  function automatic string test_name(input int t);
    case (t)
      1:       test_name = "slot_init_and_free";
      2:       test_name = "packet_done_forward";
      3:       test_name = "to_core_grant";
      4:       test_name = "disabled_core_wait";
      5:       test_name = "flush_then_refill";
      6:       test_name = "stalled_mixed_burst";
      default: test_name = "unknown";
    endcase
  endfunction

  function automatic logic [31:0] slot_pl(input int n);
    return {8'd0, 8'(n), 16'd0};
  endfunction

  task automatic record_error();
    fails++;
    test_errs++;
  endtask

  task automatic add_step(input logic [2:0] k, input int t, input logic [1:0] s,
                          input logic [3:0] m, input logic [31:0] p,
                          input logic [3:0] a, input logic [31:0] d);
    steps[n_steps] = '{kind: k, test: 3'(t), src: s, msg_type: m, payload: p,
                       addr: a, data: d};
    n_steps++;
  endtask

  task automatic add_msg(input int t, input logic [1:0] s, input logic [3:0] m,
                         input logic [31:0] p);
    add_step(K_MSG, t, s, m, p, 4'd0, 32'd0);
  endtask

  task automatic add_wr(input int t, input logic [3:0] a, input logic [31:0] d);
    add_step(K_WR, t, 2'd0, 4'd0, 32'd0, a, d);
  endtask

  task automatic add_rd(input int t, input logic [3:0] a, input logic [31:0] d);
    add_step(K_RD, t, 2'd0, 4'd0, 32'd0, a, d);
  endtask

  task automatic build_table();
    logic [1:0] s;
    add_msg(1, 2'd2, 4'd3, slot_pl(5));
    add_rd(1, 4'd6, 32'd5);
    add_msg(1, 2'd2, 4'd0, slot_pl(6));
    add_msg(1, 2'd2, 4'd0, slot_pl(7));
    add_rd(1, 4'd6, 32'd7);
    add_rd(1, 4'd2, 32'd0);
    add_msg(1, 2'd2, 4'd0, slot_pl(8));
    // Pool already full so this slot is dropped
    add_msg(1, 2'd2, 4'd0, slot_pl(9));
    add_rd(1, 4'd6, 32'd8);
    add_rd(1, 4'd2, 32'd1);
    add_wr(1, 4'd2, 32'd0);
    add_rd(1, 4'd2, 32'd0);
    add_msg(2, 2'd1, 4'd1, $random(seed));
    add_msg(3, 2'd3, 4'd3, slot_pl(4));
    add_wr(3, 4'd0, 32'h8);
    add_rd(3, 4'd7, 32'd4);
    add_msg(3, 2'd0, 4'd2, {8'd3, 8'd5, 16'($random(seed))});
    add_rd(3, 4'd7, 32'd3);
    add_rd(3, 4'd0, 32'h8);
    add_msg(4, 2'd1, 4'd3, slot_pl(3));
    add_msg(4, 2'd2, 4'd2, {8'd1, 8'd9, 16'($random(seed))});
    add_rd(4, 4'd5, 32'd3);
    add_wr(4, 4'd0, 32'ha);
    add_rd(4, 4'd5, 32'd2);
    add_wr(5, 4'd1, 32'h4);
    add_rd(5, 4'd6, 32'd0);
    add_wr(5, 4'd0, 32'he);
    add_msg(5, 2'd1, 4'd2, {8'd2, 8'd12, 16'($random(seed))});
    add_rd(5, 4'd6, 32'd0);
    add_msg(5, 2'd2, 4'd0, slot_pl(6));
    add_rd(5, 4'd6, 32'd0);
    add_wr(6, 4'd0, 32'hf);
    for (int c = 0; c < `LB_CORE_COUNT; c++) begin
      add_msg(6, 2'(c), 4'd3, slot_pl(8));
    end
    add_step(K_RDY, 6, 2'd0, 4'd0, 32'd0, 4'd0, 32'd2);
    // Targets rotate so no pool runs dry
    for (int i = 0; i < 20; i++) begin
      s = 2'($random(seed));
      if (($random(seed) & 1) != 0) begin
        add_msg(6, s, 4'd1, $random(seed));
      end else begin
        add_msg(6, s, 4'd2, {8'(i % 4), 8'($random(seed)), 16'($random(seed))});
      end
    end
    add_step(K_RDY, 6, 2'd0, 4'd0, 32'd0, 4'd0, 32'd1);
  endtask

  // Grant waiting requests in arrival order per target core
  task automatic run_grants();
    bit          found;
    logic [33:0] r;
    logic [3:0]  s;
    for (int t = 0; t < `LB_CORE_COUNT; t++) begin
      found = 1'b1;
      while (found) begin
        found = 1'b0;
        if (enable_m[t] && pool_cnt[t] > 0) begin
          for (int k = 0; k < pend_q.size() && !found; k++) begin
            if (pend_q[k][25:24] == 2'(t)) begin
              found = 1'b1;
              r = pend_q[k];
              pend_q.delete(k);
            end
          end
          if (found) begin
            s = pool[t][pool_head[t]];
            pool_head[t] = (pool_head[t] + 1) % `LB_SLOT_COUNT;
            pool_cnt[t]--;
            exp_q.push_back({5'(4 + 4 * r[33:32] + t), 4'd1,
                             8'(`LB_LOOPBACK_PORT), r[23:16], 4'(t), 12'(s)});
          end
        end
      end
    end
  endtask

  task automatic model_msg(input logic [1:0] src, input logic [3:0] m, input logic [31:0] p);
    case (m)
      4'd0: begin
        if (pool_cnt[src] < `LB_SLOT_COUNT) begin
          pool[src][(pool_head[src] + pool_cnt[src]) % `LB_SLOT_COUNT] = p[19:16];
          pool_cnt[src]++;
        end
      end
      4'd1: exp_q.push_back({5'(src), 4'd0, p});
      4'd2: pend_q.push_back({src, p});
      4'd3: begin
        pool_head[src] = 0;
        pool_cnt[src]  = (p[23:16] > `LB_SLOT_COUNT) ? `LB_SLOT_COUNT : int'(p[23:16]);
        for (int i = 0; i < `LB_SLOT_COUNT; i++) begin
          pool[src][i] = 4'(i + 1);
        end
      end
      default: ;
    endcase
    run_grants();
  endtask

  task automatic model_write(input logic [3:0] a, input logic [31:0] d);
    if (a == 4'd0) begin
      enable_m = d[3:0];
    end
    if (a == 4'd1) begin
      for (int c = 0; c < `LB_CORE_COUNT; c++) begin
        if (d[c]) begin
          pool_cnt[c]  = 0;
          pool_head[c] = 0;
        end
      end
    end
    run_grants();
  endtask

  task automatic check_beat();
    logic [35:0] act;
    int          stream;
    bit          found;
    act    = ctrl_out;
    stream = (act[35:32] == 4'd0) ? int'(ctrl_out_dest) : 4 + 4 * ctrl_out_dest + act[15:12];
    found  = 1'b0;
    checks++;
    for (int k = 0; k < exp_q.size() && !found; k++) begin
      if (exp_q[k][40:36] == 5'(stream)) begin
        found = 1'b1;
        if (exp_q[k][35:0] !== act) begin
          $display("[FAIL] %s: beat to core %0d expected %h actual %h",
                   test_name(cur_test), ctrl_out_dest, exp_q[k][35:0], act);
          record_error();
        end
        exp_q.delete(k);
      end
    end
    if (!found) begin
      $display("%s: unexpected outbound beat %h to core %0d",
               test_name(cur_test), act, ctrl_out_dest);
      record_error();
    end
  endtask

  // Wait for all expected beats and let slot updates land
  task automatic settle();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic send_msg(input step_t s);
    bit taken;
    @(posedge clk);
    ctrl_in       <= lb_ctrl_msg_t'({s.msg_type, s.payload});
    ctrl_in_src   <= s.src;
    ctrl_in_valid <= 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = ctrl_in_ready;
      @(posedge clk);
    end
    ctrl_in_valid <= 1'b0;
    model_msg(s.src, s.msg_type, s.payload);
  endtask

  task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
    @(posedge clk);
    cfg_req <= '{wr: 1'b1, rd: 1'b0, addr: a, wdata: d};
    @(posedge clk);
    cfg_req <= '0;
    model_write(a, d);
  endtask

  task automatic reg_read(input logic [3:0] a, input logic [31:0] expv);
    settle();
    @(posedge clk);
    cfg_req <= '{wr: 1'b0, rd: 1'b1, addr: a, wdata: 32'd0};
    @(posedge clk);
    cfg_req <= '0;
    @(negedge clk);
    checks++;
    if (!cfg_rvalid) begin
      $display("%s: no read response for address %0d", test_name(cur_test), a);
      record_error();
    end else if (cfg_rdata !== expv) begin
      $display("[FAIL] %s: read addr %0d expected %0h actual %0h",
               test_name(cur_test), a, expv, cfg_rdata);
      record_error();
    end
  endtask

  task automatic finish_test(input int t);
    settle();
    if (test_errs == 0) begin
      $display("%s: passed", test_name(t));
    end else begin
      $display("%s: failed with %0d errors", test_name(t), test_errs);
    end
    test_errs = 0;
  endtask

  // Watchdog sized from the table length
  initial begin
    wait (built);
    repeat (n_steps * 50) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", n_steps * 50);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    ctrl_in        = '0;
    ctrl_in_valid  = 1'b0;
    ctrl_in_src    = '0;
    ctrl_out_ready = 1'b1;
    cfg_req        = '0;
    seed           = 98;
    n_steps        = 0;
    rdy_mode       = 1;
    checks         = 0;
    fails          = 0;
    test_errs      = 0;
    enable_m       = '0;
    for (int c = 0; c < `LB_CORE_COUNT; c++) begin
      pool_head[c] = 0;
      pool_cnt[c]  = 0;
    end
    build_table();
    built = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    cur_test = steps[0].test;
    for (int i = 0; i < n_steps; i++) begin
      if (steps[i].test != cur_test) begin
        finish_test(cur_test);
        cur_test = steps[i].test;
      end
      case (steps[i].kind)
        K_WR:    reg_write(steps[i].addr, steps[i].data);
        K_RD:    reg_read(steps[i].addr, steps[i].data);
        K_MSG:   send_msg(steps[i]);
        default: rdy_mode <= steps[i].data;
      endcase
    end
    finish_test(cur_test);
    if (pend_q.size() != 0) begin
      $display("%0d to-core requests were never granted", pend_q.size());
      fails++;
    end
    $display("Summary: %0d checks, %0d failures", checks, fails);
    if (fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
lb_pkg.sv
lb_fifo.sv
slot_keeper.sv
lb_controller.sv
lb_config_regs.sv
lb_top.sv
tb_lb_top.sv

// File: Bender.yml
package:
  name: lb_control_plane

sources:
  - include_dirs:
      - .
    files:
      - lb_pkg.sv
      - lb_fifo.sv
      - slot_keeper.sv
      - lb_controller.sv
      - lb_config_regs.sv
      - lb_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_lb_top.sv
